/* src/lsu_pkg.sv */
// shared types that the load/store unit and data memory reference by scoped name
`default_nettype none

package lsu_pkg;

    // ------------------------------
    // basic widths
    // ------------------------------
    typedef logic [63:0] bus64_t;
    typedef logic [39:0] addr_t; // physical address
    typedef logic [4:0]  reg_t;

    typedef enum logic [1:0] {
        mem_load  = 2'd0,
        mem_store = 2'd1,
        mem_amo   = 2'd2
    } mem_op_t;

    typedef enum logic [3:0] {
        amo_lr, amo_sc, amo_swap, amo_add, amo_xor, amo_and,
        amo_or, amo_min, amo_max, amo_minu, amo_maxu
    } amo_op_t;

    // data cache command codes
    typedef enum logic [4:0] {
        cmd_load  = 5'b00000,
        cmd_store = 5'b00001,
        cmd_swap  = 5'b00100,
        cmd_lr    = 5'b00110,
        cmd_sc    = 5'b00111,
        cmd_add   = 5'b01000,
        cmd_xor   = 5'b01001,
        cmd_or    = 5'b01010,
        cmd_and   = 5'b01011,
        cmd_min   = 5'b01100,
        cmd_max   = 5'b01101,
        cmd_minu  = 5'b01110,
        cmd_maxu  = 5'b01111
    } dmem_cmd_t;

    typedef enum logic [1:0] {
        xcpt_none       = 2'd0,
        xcpt_misaligned = 2'd1,
        xcpt_access     = 2'd2
    } xcpt_t;

    // ------------------------------
    // bundles
    // ------------------------------
    typedef struct packed {
        mem_op_t    mem_op;
        amo_op_t    amo_op;
        logic [2:0] funct3;
        reg_t       rd;
        bus64_t     rs1_data;
        bus64_t     rs2_data;
        bus64_t     imm;
    } lsu_op_t;

    typedef struct packed {
        dmem_cmd_t  cmd;
        addr_t      addr;
        logic [2:0] funct3;        // size in [1:0], unsigned in [2]
        bus64_t     data;
        logic [7:0] tag;
        logic       invalidate_lr;
        logic       kill;
    } dmem_req_t;

    typedef struct packed {
        bus64_t     data;
        logic [7:0] tag;
        logic       ma_ld;
        logic       ma_st;
        logic       af_ld;
        logic       af_st;
    } dmem_resp_t;

    typedef struct packed {
        reg_t   rd;
        bus64_t data;
        xcpt_t  xcpt;
    } lsu_wb_t;

endpackage

`default_nettype wire

/* src/lsu_cmd_encoder.sv */
// combinational encoder from a pipeline memory operation to a data cache request
`timescale 1ns/1ps
`default_nettype none

module lsu_cmd_encoder (
    input  lsu_pkg::lsu_op_t   op_i,
    output lsu_pkg::dmem_req_t req_o
);

    lsu_pkg::dmem_cmd_t cmd;

    // ------------------------------
    // command code
    // ------------------------------
    always_comb begin
        cmd = lsu_pkg::cmd_load;
        case (op_i.mem_op)
            lsu_pkg::mem_load:  cmd = lsu_pkg::cmd_load;
            lsu_pkg::mem_store: cmd = lsu_pkg::cmd_store;
            lsu_pkg::mem_amo: begin
                case (op_i.amo_op)
                    lsu_pkg::amo_lr:   cmd = lsu_pkg::cmd_lr;
                    lsu_pkg::amo_sc:   cmd = lsu_pkg::cmd_sc;
                    lsu_pkg::amo_swap: cmd = lsu_pkg::cmd_swap;
                    lsu_pkg::amo_add:  cmd = lsu_pkg::cmd_add;
                    lsu_pkg::amo_xor:  cmd = lsu_pkg::cmd_xor;
                    lsu_pkg::amo_and:  cmd = lsu_pkg::cmd_and;
                    lsu_pkg::amo_or:   cmd = lsu_pkg::cmd_or;
                    lsu_pkg::amo_min:  cmd = lsu_pkg::cmd_min;
                    lsu_pkg::amo_max:  cmd = lsu_pkg::cmd_max;
                    lsu_pkg::amo_minu: cmd = lsu_pkg::cmd_minu;
                    lsu_pkg::amo_maxu: cmd = lsu_pkg::cmd_maxu;
                    default:           cmd = lsu_pkg::cmd_load;
                endcase
            end
            default: cmd = lsu_pkg::cmd_load;
        endcase
    end

    // ------------------------------
    // request fields
    // ------------------------------
    always_comb begin
        req_o.cmd = cmd;
        // atomics take rs1 as is without an offset
        if (op_i.mem_op == lsu_pkg::mem_amo) begin
            req_o.addr = op_i.rs1_data[39:0];
        end else begin
            req_o.addr = op_i.rs1_data[39:0] + op_i.imm[39:0];
        end
        req_o.funct3        = op_i.funct3;
        req_o.data          = op_i.rs2_data;
        req_o.tag           = {2'b00, op_i.rd, 1'b0}; // bit 0 is the fp flag, always clear
        req_o.invalidate_lr = 1'b0;                  // filled in by the controller
        req_o.kill          = 1'b0;
    end

endmodule

`default_nettype wire

/* src/lsu_ctrl.sv */
// request/response FSM of the load/store unit that drives the stall and the writeback
`timescale 1ns/1ps
`default_nettype none

module lsu_ctrl #(
    parameter lsu_pkg::addr_t io_base_addr = 40'h0080000000
) (
    input  wire                 clk_i,
    input  wire                 rstn_i,
    input  wire                 valid_i,
    input  wire                 kill_i,
    input  wire                 csr_eret_i,
    input  lsu_pkg::dmem_req_t  enc_req_i,
    input  wire                 req_ready_i,
    input  wire                 resp_valid_i,
    input  lsu_pkg::dmem_resp_t resp_i,
    output logic                req_valid_o,
    output lsu_pkg::dmem_req_t  req_o,
    output logic                lock_o,
    output logic                wb_valid_o,
    output lsu_pkg::lsu_wb_t    wb_o
);

    typedef enum logic [1:0] {
        st_reset,
        st_idle,
        st_request,
        st_wait
    } state_t;

    state_t state_q;
    state_t state_d;
    logic   io_store;     // outstanding op is a store to the io register
    logic   release_early;
    logic   any_xcpt;

    assign io_store = (enc_req_i.cmd == lsu_pkg::cmd_store) &&
                      (enc_req_i.addr == io_base_addr);
    assign release_early = kill_i | io_store;

    // ------------------------------
    // state machine
    // ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= st_reset;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d     = state_q;
        req_valid_o = 1'b0;
        lock_o      = 1'b0;
        case (state_q)
            st_reset: state_d = st_idle;
            st_idle: begin
                // back-pressure keeps the lock up without issuing
                req_valid_o = valid_i & ~kill_i & req_ready_i;
                lock_o      = valid_i & ~kill_i;
                state_d     = req_valid_o ? st_request : st_idle;
            end
            st_request: begin
                lock_o  = ~release_early;
                state_d = release_early ? st_idle : st_wait;
            end
            st_wait: begin
                if (resp_valid_i) begin
                    state_d = st_idle;
                end else begin
                    lock_o  = ~release_early;
                    state_d = release_early ? st_idle : st_wait;
                end
            end
            default: state_d = st_reset;
        endcase
    end

    // request toward memory
    always_comb begin
        req_o               = enc_req_i;
        req_o.invalidate_lr = csr_eret_i;
        req_o.kill          = kill_i;
    end

    // ------------------------------
    // writeback
    // ------------------------------
    assign any_xcpt = resp_i.ma_ld | resp_i.ma_st | resp_i.af_ld | resp_i.af_st;

    // a clean store has nothing to write back
    assign wb_valid_o = resp_valid_i &
                        ~((enc_req_i.cmd == lsu_pkg::cmd_store) & ~any_xcpt);

    always_comb begin
        wb_o.rd   = resp_i.tag[5:1];
        wb_o.data = resp_i.data;
        if (resp_i.ma_ld | resp_i.ma_st) begin
            wb_o.xcpt = lsu_pkg::xcpt_misaligned;
        end else if (resp_i.af_ld | resp_i.af_st) begin
            wb_o.xcpt = lsu_pkg::xcpt_access;
        end else begin
            wb_o.xcpt = lsu_pkg::xcpt_none;
        end
    end

    // an issue never overlaps a response still in flight
    a_issue_from_idle: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_valid_o |-> !resp_valid_i);

    // after a response only a freshly presented op may raise the lock
    a_unlock_after_resp: assert property (@(posedge clk_i) disable iff (!rstn_i)
        resp_valid_i |=> !lock_o || (valid_i && !kill_i));

endmodule

`default_nettype wire

/* src/dmem_model.sv */
// data memory model behind the load/store unit with RAM, io register, LR/SC and AMOs
`timescale 1ns/1ps
`default_nettype none

module dmem_model #(
    parameter int unsigned    mem_depth_log2 = 8,
    parameter lsu_pkg::addr_t io_base_addr   = 40'h0080000000
) (
    input  wire                  clk_i,
    input  wire                  rstn_i,
    input  wire                  req_valid_i,
    input  lsu_pkg::dmem_req_t   req_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output lsu_pkg::dmem_resp_t  resp_o
);

    lsu_pkg::bus64_t ram [0:(1 << mem_depth_log2) - 1];
    lsu_pkg::bus64_t io_reg;

    lsu_pkg::dmem_req_t  req_q;
    lsu_pkg::dmem_resp_t resp_q;
    lsu_pkg::dmem_resp_t resp_d;
    lsu_pkg::bus64_t     old_q;      // AMO read value from C1
    lsu_pkg::addr_t      resv_addr_q;
    logic                resv_valid_q;
    logic                busy_q;
    logic                amo_ph_q;   // second half of an AMO
    logic                resp_valid_q;

    logic [mem_depth_log2-1:0] idx;
    logic [2:0]                off;
    logic                      accept, io_store_acc;
    logic                      phase0, phase1;
    logic                      mis, af, xcpt, is_io, is_ld, is_rmw, sc_ok;
    logic                      wr_en;
    lsu_pkg::bus64_t           rd_data, amo_a, amo_b, amo_res, wr_data;

    function automatic lsu_pkg::bus64_t load_ext(input lsu_pkg::bus64_t word,
                                                 input logic [2:0] lane,
                                                 input logic [2:0] f3);
        lsu_pkg::bus64_t sh;
        sh = word >> {lane, 3'b000};
        case (f3)
            3'd0:    return {{56{sh[7]}}, sh[7:0]};
            3'd1:    return {{48{sh[15]}}, sh[15:0]};
            3'd2:    return {{32{sh[31]}}, sh[31:0]};
            3'd4:    return {56'b0, sh[7:0]};
            3'd5:    return {48'b0, sh[15:0]};
            3'd6:    return {32'b0, sh[31:0]};
            default: return sh;
        endcase
    endfunction

    function automatic lsu_pkg::bus64_t store_merge(input lsu_pkg::bus64_t old,
                                                    input lsu_pkg::bus64_t data,
                                                    input logic [2:0] lane,
                                                    input logic [2:0] f3);
        lsu_pkg::bus64_t mask;
        case (f3[1:0])
            2'd0:    mask = 64'h00000000000000ff;
            2'd1:    mask = 64'h000000000000ffff;
            2'd2:    mask = 64'h00000000ffffffff;
            default: mask = '1;
        endcase
        mask = mask << {lane, 3'b000};
        return (old & ~mask) | ((data << {lane, 3'b000}) & mask);
    endfunction

    // ------------------------------
    // decode of the held request
    // ------------------------------
    assign idx   = req_q.addr[mem_depth_log2+2:3];
    assign off   = req_q.addr[2:0];
    assign is_io = (req_q.addr == io_base_addr);
    assign is_ld = (req_q.cmd == lsu_pkg::cmd_load) || (req_q.cmd == lsu_pkg::cmd_lr);
    assign is_rmw = (req_q.cmd == lsu_pkg::cmd_swap) || req_q.cmd[3];
    assign sc_ok  = resv_valid_q && (resv_addr_q == req_q.addr);

    always_comb begin
        case (req_q.funct3[1:0])
            2'd0:    mis = 1'b0;
            2'd1:    mis = req_q.addr[0];
            2'd2:    mis = |req_q.addr[1:0];
            default: mis = |req_q.addr[2:0];
        endcase
    end
    assign af   = (req_q.addr[39:mem_depth_log2+3] != '0) && !is_io;
    assign xcpt = mis | af;

    assign accept       = req_valid_i & ~busy_q;
    assign io_store_acc = accept && (req_i.cmd == lsu_pkg::cmd_store) &&
                          (req_i.addr == io_base_addr);
    assign phase0 = busy_q & ~amo_ph_q & ~req_i.kill;
    assign phase1 = busy_q & amo_ph_q & ~req_i.kill;

    assign rd_data = is_io ? io_reg : ram[idx];

    // word AMOs use the sign-extended lane
    assign amo_a = load_ext(old_q, off, req_q.funct3);
    assign amo_b = (req_q.funct3[1:0] == 2'd2) ? {{32{req_q.data[31]}}, req_q.data[31:0]}
                                                : req_q.data;
    always_comb begin
        case (req_q.cmd)
            lsu_pkg::cmd_add:  amo_res = amo_a + amo_b;
            lsu_pkg::cmd_xor:  amo_res = amo_a ^ amo_b;
            lsu_pkg::cmd_and:  amo_res = amo_a & amo_b;
            lsu_pkg::cmd_or:   amo_res = amo_a | amo_b;
            lsu_pkg::cmd_min:  amo_res = ($signed(amo_a) < $signed(amo_b)) ? amo_a : amo_b;
            lsu_pkg::cmd_max:  amo_res = ($signed(amo_a) > $signed(amo_b)) ? amo_a : amo_b;
            lsu_pkg::cmd_minu: amo_res = (amo_a < amo_b) ? amo_a : amo_b;
            lsu_pkg::cmd_maxu: amo_res = (amo_a > amo_b) ? amo_a : amo_b;
            default:           amo_res = amo_b; // swap
        endcase
    end

    assign wr_en = ~xcpt & ((phase0 & ((req_q.cmd == lsu_pkg::cmd_store) |
                                       ((req_q.cmd == lsu_pkg::cmd_sc) & sc_ok))) | phase1);
    assign wr_data = phase1 ? store_merge(old_q, amo_res, off, req_q.funct3)
                            : store_merge(rd_data, req_q.data, off, req_q.funct3);

    // response contents for C2 or C3
    always_comb begin
        resp_d.tag   = req_q.tag;
        resp_d.data  = '0;
        resp_d.ma_ld = phase0 & mis & is_ld;
        resp_d.ma_st = phase0 & mis & ~is_ld;
        resp_d.af_ld = phase0 & ~mis & af & is_ld;
        resp_d.af_st = phase0 & ~mis & af & ~is_ld;
        if (phase1) begin
            resp_d.data = load_ext(old_q, off, req_q.funct3);
        end else if (!xcpt && is_ld) begin
            resp_d.data = load_ext(rd_data, off, req_q.funct3);
        end else if (!xcpt && req_q.cmd == lsu_pkg::cmd_sc) begin
            resp_d.data = {63'b0, ~sc_ok}; // 0 on success
        end
    end

    // ------------------------------
    // control state
    // ------------------------------
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q       <= 1'b0;
            amo_ph_q     <= 1'b0;
            resp_valid_q <= 1'b0;
            resv_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= 1'b0;
            if (accept && !io_store_acc) begin
                busy_q   <= 1'b1;
                amo_ph_q <= 1'b0;
            end else if (busy_q && req_i.kill) begin
                busy_q   <= 1'b0; // dropped without a response
                amo_ph_q <= 1'b0;
            end else if (phase0 && !xcpt && is_rmw) begin
                amo_ph_q <= 1'b1;
            end else if (phase0 || phase1) begin
                busy_q       <= 1'b0;
                amo_ph_q     <= 1'b0;
                resp_valid_q <= 1'b1;
            end
            if (req_i.invalidate_lr) begin
                resv_valid_q <= 1'b0;
            end else if (phase0 && req_q.cmd == lsu_pkg::cmd_sc) begin
                resv_valid_q <= 1'b0;
            end else if (phase0 && !xcpt && req_q.cmd == lsu_pkg::cmd_lr) begin
                resv_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) req_q <= req_i;
        if (phase0) old_q <= rd_data;
        if (phase0 && req_q.cmd == lsu_pkg::cmd_lr) resv_addr_q <= req_q.addr;
        if (phase0 || phase1) resp_q <= resp_d;
        if (wr_en && !is_io) ram[idx] <= wr_data;
        if (io_store_acc) begin
            io_reg <= store_merge(io_reg, req_i.data, req_i.addr[2:0], req_i.funct3);
        end else if (wr_en && is_io) begin
            io_reg <= wr_data;
        end
    end

    assign req_ready_o  = ~busy_q;
    assign resp_valid_o = resp_valid_q;
    assign resp_o       = resp_q;

    // a killed AMO must not answer in its C3 either
    a_no_resp_after_kill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        busy_q && req_i.kill |=> !resp_valid_o ##1 !resp_valid_o);

endmodule

`default_nettype wire

/* src/lsu_top.sv */
// load/store unit top that wires the command encoder, controller and data memory together
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
    parameter int unsigned    mem_depth_log2 = 8,
    parameter lsu_pkg::addr_t io_base_addr   = 40'h0080000000
) (
    input  wire               clk_i,
    input  wire               rstn_i,
    input  wire               valid_i,
    input  wire               kill_i,
    input  wire               csr_eret_i,
    input  lsu_pkg::lsu_op_t  op_i,
    output logic              lock_o,
    output logic              wb_valid_o,
    output lsu_pkg::lsu_wb_t  wb_o
);

    lsu_pkg::dmem_req_t  enc_req;  // straight from the encoder
    lsu_pkg::dmem_req_t  mem_req;  // with kill and invalidate_lr
    lsu_pkg::dmem_resp_t mem_resp;
    logic                req_valid;
    logic                req_ready;
    logic                resp_valid;

    // ------------------------------
    // pipeline side
    // ------------------------------
    lsu_cmd_encoder u_enc (
        .op_i  (op_i),
        .req_o (enc_req)
    );

    lsu_ctrl #(
        .io_base_addr (io_base_addr)
    ) u_ctrl (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .valid_i      (valid_i),
        .kill_i       (kill_i),
        .csr_eret_i   (csr_eret_i),
        .enc_req_i    (enc_req),
        .req_ready_i  (req_ready),
        .resp_valid_i (resp_valid),
        .resp_i       (mem_resp),
        .req_valid_o  (req_valid),
        .req_o        (mem_req),
        .lock_o       (lock_o),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

    // memory side
    dmem_model #(
        .mem_depth_log2 (mem_depth_log2),
        .io_base_addr   (io_base_addr)
    ) u_dmem (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_valid_i  (req_valid),
        .req_i        (mem_req),
        .req_ready_o  (req_ready),
        .resp_valid_o (resp_valid),
        .resp_o       (mem_resp)
    );

endmodule

`default_nettype wire

/* dv/tb_lsu_top.sv */
// testbench for lsu_top that replays the golden operation list and checks lock, writeback and xcpt
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

    localparam int unsigned    mem_depth_log2 = 8;
    localparam lsu_pkg::addr_t io_base_addr   = 40'h0080000000;
    localparam int             max_ops        = 64;

    logic             clk_i;
    logic             rstn_i;
    logic             valid;
    logic             kill;
    logic             eret;
    lsu_pkg::lsu_op_t op;
    logic             lock;
    logic             wb_valid;
    lsu_pkg::lsu_wb_t wb;

    // golden table with one entry per operation
    lsu_pkg::lsu_op_t ops [max_ops];
    int               kill_cyc [max_ops];  // 0 means not killed
    logic             eret_flag [max_ops];
    logic             exp_wb [max_ops];
    lsu_pkg::bus64_t  exp_data [max_ops];
    logic [1:0]       exp_xcpt [max_ops];

    int num_ops     = 0;
    int errors      = 0;
    int cycles      = 0;
    int cycle_limit = 50;
    int seed        = 32'h1bbff602;

    lsu_top #(
        .mem_depth_log2 (mem_depth_log2),
        .io_base_addr   (io_base_addr)
    ) uut (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .valid_i    (valid),
        .kill_i     (kill),
        .csr_eret_i (eret),
        .op_i       (op),
        .lock_o     (lock),
        .wb_valid_o (wb_valid),
        .wb_o       (wb)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // run limit that grows with the golden file
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the operation list did not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    // ------------------------------
    // golden file
    // ------------------------------
    task automatic read_golden();
        int          fd;
        int          n;
        string       line;
        logic [63:0] m_op, a_op, f3, rd;
        logic [63:0] rs1, rs2, imm, kc;
        logic [63:0] er, wbf, dat, xc;
        fd = $fopen("dv/lsu_golden.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open dv/lsu_golden.txt, no operation was run");
            return;
        end
        while ($fgets(line, fd) > 0 && num_ops < max_ops) begin
            if (line.len() > 1 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            m_op, a_op, f3, rd, rs1, rs2, imm, kc, er, wbf, dat, xc);
                if (n != 12) begin
                    errors++;
                    $display("golden line could not be parsed: %s", line);
                end else begin
                    ops[num_ops].mem_op   = lsu_pkg::mem_op_t'(m_op[1:0]);
                    ops[num_ops].amo_op   = lsu_pkg::amo_op_t'(a_op[3:0]);
                    ops[num_ops].funct3   = f3[2:0];
                    ops[num_ops].rd       = rd[4:0];
                    ops[num_ops].rs1_data = rs1;
                    ops[num_ops].rs2_data = rs2;
                    ops[num_ops].imm      = imm;
                    kill_cyc[num_ops]     = kc[31:0];
                    eret_flag[num_ops]    = er[0];
                    exp_wb[num_ops]       = wbf[0];
                    exp_data[num_ops]     = dat;
                    exp_xcpt[num_ops]     = xc[1:0];
                    num_ops++;
                end
            end
        end
        $fclose(fd);
        cycle_limit = 10 * num_ops + 50;
    endtask

    // ------------------------------
    // one operation from C0 to C3
    // ------------------------------
    task automatic run_op(input int i);
        lsu_pkg::addr_t addr;
        int             rel;  // cycle in which lock drops
        int             c;
        logic           exp_lock;
        logic           exp_wbv;
        if (ops[i].mem_op == lsu_pkg::mem_amo) begin
            addr = ops[i].rs1_data[39:0];
        end else begin
            addr = ops[i].rs1_data[39:0] + ops[i].imm[39:0];
        end
        if (kill_cyc[i] != 0) begin
            rel = kill_cyc[i];
        end else if (ops[i].mem_op == lsu_pkg::mem_store && addr == io_base_addr) begin
            rel = 1;  // io store needs no response
        end else if (ops[i].mem_op == lsu_pkg::mem_amo && ops[i].amo_op != lsu_pkg::amo_lr &&
                     ops[i].amo_op != lsu_pkg::amo_sc && exp_xcpt[i] == 2'd0) begin
            rel = 3;  // read-modify-write
        end else begin
            rel = 2;
        end
        op = ops[i];
        for (c = 0; c < 4; c++) begin
            valid = (c == 0);
            eret  = (c == 0) && eret_flag[i];
            kill  = (c != 0) && (c == kill_cyc[i]);
            #18;  // sample at the falling edge
            exp_lock = (c < rel);
            exp_wbv  = exp_wb[i] && (c == rel);
            check_value($sformatf("lock_o op %0d C%0d", i, c), 64'(exp_lock), 64'(lock));
            check_value($sformatf("wb_valid_o op %0d C%0d", i, c), 64'(exp_wbv),
                        64'(wb_valid));
            if (exp_wbv) begin
                check_value($sformatf("wb_o.rd op %0d", i), 64'(ops[i].rd), 64'(wb.rd));
                check_value($sformatf("wb_o.data op %0d", i), exp_data[i], wb.data);
                check_value($sformatf("wb_o.xcpt op %0d", i), 64'(exp_xcpt[i]), 64'(wb.xcpt));
            end
            @(posedge clk_i);
            #2;
        end
        kill = 1'b0;
    endtask

    initial begin
        int i;
        int gap;
        rstn_i = 1'b0;
        valid  = 1'b0;
        kill   = 1'b0;
        eret   = 1'b0;
        op     = '0;
        read_golden();
        repeat (10) @(posedge clk_i);
        #2;
        check_value("lock_o in reset", 64'd0, 64'(lock));
        check_value("wb_valid_o in reset", 64'd0, 64'(wb_valid));
        rstn_i = 1'b1;
        @(posedge clk_i);  // controller reset state
        #2;
        for (i = 0; i < num_ops; i++) begin
            gap = $random(seed) & 3;
            repeat (gap) begin
                @(posedge clk_i);
                #2;
            end
            run_op(i);
        end
        $display("run complete: %0d operations, %0d errors", num_ops, errors);
        if (errors == 0 && num_ops > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
src/lsu_pkg.sv
src/lsu_cmd_encoder.sv
src/lsu_ctrl.sv
src/dmem_model.sv
src/lsu_top.sv
dv/tb_lsu_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the load/store unit testbench with Verilator, then check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_lsu_top -o tb_lsu_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_lsu_top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Verification passed$" "$log"; then
    echo "simulation PASS"
    exit 0
fi

echo "simulation FAIL, see $log"
exit 1

/* dv/lsu_golden.txt */
# mem_op amo_op funct3 rd rs1 rs2 imm kill_cycle eret exp_wb exp_data exp_xcpt, all hex
# mem_op 0 load 1 store 2 amo; kill_cycle 0 means no kill; xcpt 0 none 1 misaligned 2 access
1 0 3 00 100 F0E1D2C3B4A59687 0 0 0 0 0 0
1 0 2 00 100 FFFFFFFF7EDCBA98 4 0 0 0 0 0
1 0 0 00 100 55 7 0 0 0 0 0
1 0 1 00 100 ABCD8001 2 0 0 0 0 0
0 0 3 05 108 0 FFFFFFFFFFFFFFF8 0 0 1 55DCBA9880019687 0
0 0 0 06 100 0 1 0 0 1 FFFFFFFFFFFFFF96 0
0 0 4 07 100 0 1 0 0 1 96 0
0 0 1 08 100 0 2 0 0 1 FFFFFFFFFFFF8001 0
0 0 5 09 100 0 2 0 0 1 8001 0
0 0 2 0A 100 0 0 0 0 1 FFFFFFFF80019687 0
0 0 6 0B 100 0 0 0 0 1 80019687 0
1 0 3 00 200 10 0 0 0 0 0 0
2 3 3 0C 200 5 0 0 0 1 10 0
2 4 3 0D 200 FF 0 0 0 1 15 0
2 5 3 0E 200 0F 0 0 0 1 EA 0
2 6 3 0F 200 8000000000000000 0 0 0 1 0A 0
2 8 3 10 200 1 0 0 0 1 800000000000000A 0
2 7 3 11 200 FFFFFFFFFFFFFFFE 0 0 0 1 1 0
2 9 3 12 200 7 0 0 0 1 FFFFFFFFFFFFFFFE 0
2 A 3 13 200 9000000000000000 0 0 0 1 7 0
2 2 3 14 200 0123456789ABCDEF 0 0 0 1 9000000000000000 0
0 0 3 15 200 0 0 0 0 1 0123456789ABCDEF 0
1 0 3 00 300 1111 0 0 0 0 0 0
2 0 3 16 300 0 0 0 0 1 1111 0
2 1 3 17 300 2222 0 0 0 1 0 0
2 1 3 18 300 3333 0 0 0 1 1 0
0 0 3 19 300 0 0 0 0 1 2222 0
2 0 3 1A 300 0 0 0 0 1 2222 0
2 1 3 1B 300 4444 0 0 1 1 1 0
0 0 3 1C 300 0 0 0 0 1 2222 0
0 0 3 1D 301 0 0 0 0 1 0 1
1 0 2 00 300 DEAD 2 0 0 1 0 1
0 0 2 1E 1000 0 0 0 0 1 0 2
1 0 3 00 2000 BEEF 0 0 0 1 0 2
0 0 3 1F 300 0 0 0 0 1 2222 0
1 0 3 00 300 5555 0 1 0 0 0 0
2 3 3 01 300 1 0 1 0 0 0 0
0 0 3 02 300 0 0 0 0 1 2222 0
1 0 3 00 7FFFFFF8 CAFEF00D12345678 8 0 0 0 0 0
0 0 3 03 80000000 0 0 0 0 1 CAFEF00D12345678 0
